//--- osd_config_top.f
+incdir+rtl
rtl/osd_pkg.sv
rtl/osd_status_if.sv
rtl/osd_status_loader.sv
rtl/osd_dip_decoder.sv
rtl/osd_pause_ctrl.sv
rtl/osd_config_top.sv
sim/osd_config_tb.sv

//--- rtl/osd_config_top.sv
`timescale 1ns/1ps
`default_nettype none

// osd settings block, byte port in and decoded controls out
module osd_config_top (
    input  wire logic        clk,
    input  wire logic        arst_n,
    // osd command port
    input  wire logic        cmd_strobe,
    input  wire logic        cmd_start,
    input  wire logic [7:0]  cmd_byte,
    // pause sources
    input  wire logic        game_pause,
    input  wire logic        vblank,
    // video
    output logic [11:0]      hdmi_arx,
    output logic [11:0]      hdmi_ary,
    output logic [1:0]       rotate,
    output logic             rot_control,
    output logic             en_mixing,
    output logic [2:0]       scanlines,
    output logic             bw_en,
    output logic             blend_en,
    // sound
    output logic             enable_fm,
    output logic             enable_psg,
    // dips and credits
    output logic             osd_pause,
    output logic             dip_test,
    output logic             dip_flip,
    output logic [1:0]       dip_fxlevel,
    output logic             dip_pause
);

    osd_status_if st_if ();

    osd_status_loader loader_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .cmd_strobe (cmd_strobe),
        .cmd_start  (cmd_start),
        .cmd_byte   (cmd_byte),
        .st         (st_if.loader)
    );

    osd_dip_decoder decoder_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .st          (st_if.consumer),
        .hdmi_arx    (hdmi_arx),
        .hdmi_ary    (hdmi_ary),
        .rotate      (rotate),
        .rot_control (rot_control),
        .en_mixing   (en_mixing),
        .scanlines   (scanlines),
        .bw_en       (bw_en),
        .blend_en    (blend_en),
        .enable_fm   (enable_fm),
        .enable_psg  (enable_psg),
        .osd_pause   (osd_pause),
        .dip_test    (dip_test),
        .dip_flip    (dip_flip),
        .dip_fxlevel (dip_fxlevel)
    );

    osd_pause_ctrl pause_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .st         (st_if.consumer),
        .game_pause (game_pause),
        .vblank     (vblank),
        .dip_pause  (dip_pause)
    );

endmodule

`default_nettype wire

//--- rtl/osd_defs.svh
`ifndef OSD_DEFS_SVH
`define OSD_DEFS_SVH

// board target
// 1 reads the scaler bits as a scanline level (mister), 0 as a video mode (mist)
`define OSD_TARGET_MISTER 1

// 1 keeps the rotation logic for vertical games
`define OSD_VERTICAL_SCREEN 1

// native aspect ratio of the game screen
`define OSD_ARX 12'd4
`define OSD_ARY 12'd3

// command codes from the osd microcontroller
`define OSD_CMD_STATUS   8'h1E   // four data bytes follow, lsb first
`define OSD_CMD_CORE_MOD 8'h01   // one data byte follows, low 7 bits used

// committed status after reset
`define OSD_STATUS_RESET 32'h0000_0000

`endif

//--- rtl/osd_dip_decoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "osd_defs.svh"

// turns the committed status into video, sound and dip controls
module osd_dip_decoder (
    input  wire logic        clk,
    input  wire logic        arst_n,
    osd_status_if.consumer   st,
    output logic [11:0]      hdmi_arx,
    output logic [11:0]      hdmi_ary,
    output logic [1:0]       rotate,
    output logic             rot_control,
    output logic             en_mixing,
    output logic [2:0]       scanlines,
    output logic             bw_en,
    output logic             blend_en,
    output logic             enable_fm,
    output logic             enable_psg,
    output logic             osd_pause,
    output logic             dip_test,
    output logic             dip_flip,
    output logic [1:0]       dip_fxlevel
);

    localparam bit          MISTER   = (`OSD_TARGET_MISTER != 0);
    localparam bit          VERTICAL = (`OSD_VERTICAL_SCREEN != 0);
    localparam logic [11:0] ARX      = `OSD_ARX;
    localparam logic [11:0] ARY      = `OSD_ARY;

    logic [31:0] raw;          // flat view for the shared bits
    logic        tate;         // screen is rotated (vertical game)
    logic [2:0]  mist_scan;
    logic        mist_bw;
    logic        mist_blend;
    logic [2:0]  d_scanlines;
    logic        d_bw;
    logic        d_blend;
    logic [11:0] d_arx;
    logic [11:0] d_ary;

    assign raw = st.status;

    // plain rewirings, no register
    assign dip_test    = ~st.status.mister.test;   // dips are active low
    assign dip_flip    = ~st.status.mister.flip;
    assign osd_pause   = st.status.mister.credits;
    assign rot_control = MISTER ? 1'b0 : (VERTICAL && st.status.mist.rot_ctl);

    // mister rotates unless the user asks for the original screen
    assign tate = VERTICAL && st.core_mod[0] &&
                  (MISTER ? !st.status.mister.rot_off : 1'b1);

    // mist video mode table
    always_comb begin
        case (st.status.mist.video_mode)
            osd_pkg::pass_thru: begin
                mist_scan  = 3'd0;
                mist_bw    = 1'b0;
                mist_blend = 1'b0;
            end
            osd_pkg::linear: begin      // interpolation only
                mist_scan  = 3'd0;
                mist_bw    = 1'b0;
                mist_blend = 1'b1;
            end
            osd_pkg::analogue: begin
                mist_scan  = 3'd0;
                mist_bw    = 1'b1;
                mist_blend = 1'b1;
            end
            osd_pkg::analogue_scan: begin
                mist_scan  = 3'd1;
                mist_bw    = 1'b1;
                mist_blend = 1'b1;
            end
            default: begin
                mist_scan  = 3'd0;
                mist_bw    = 1'b0;
                mist_blend = 1'b0;
            end
        endcase
    end

    assign d_scanlines = MISTER ? st.status.mister.scanlines : mist_scan;
    assign d_bw        = MISTER ? 1'b0 : mist_bw;
    assign d_blend     = MISTER ? 1'b0 : mist_blend;

    // wide beats rotation, rotation swaps the native ratio
    assign d_arx = st.status.mister.wide ? 12'd16 : (tate ? ARY : ARX);
    assign d_ary = st.status.mister.wide ? 12'd9  : (tate ? ARX : ARY);

    // reloaded on each commit, reset to the decode of a zero status
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hdmi_arx    <= ARX;
            hdmi_ary    <= ARY;
            rotate      <= 2'b10;
            en_mixing   <= 1'b1;
            scanlines   <= 3'd0;
            bw_en       <= 1'b0;
            blend_en    <= 1'b0;
            enable_fm   <= 1'b1;
            enable_psg  <= 1'b1;
            dip_fxlevel <= 2'b10;
        end else if (st.upd) begin
            hdmi_arx    <= d_arx;
            hdmi_ary    <= d_ary;
            rotate      <= {~st.status.mister.flip, tate && !rot_control};
            en_mixing   <= ~raw[3];                        // screen filter
            scanlines   <= d_scanlines;
            bw_en       <= d_bw;
            blend_en    <= d_blend;
            enable_fm   <= ~st.status.mister.fm_off;
            enable_psg  <= ~st.status.mister.psg_off;
            dip_fxlevel <= 2'b10 ^ st.status.mister.fx_level; // 0 maps to high
        end
    end

    a_arx_nonzero : assert property (
        @(posedge clk) disable iff (!arst_n) hdmi_arx != 12'd0
    );

    // loader holds the old word until the last byte lands
    a_status_hold : assert property (
        @(posedge clk) disable iff (!arst_n) st.busy |-> $stable(st.status)
    );

endmodule

`default_nettype wire

//--- rtl/osd_pause_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

// game pause, applied only at the start of vertical blank
module osd_pause_ctrl (
    input  wire logic      clk,
    input  wire logic      arst_n,
    osd_status_if.consumer st,
    input  wire logic      game_pause,
    input  wire logic      vblank,
    output logic           dip_pause  // active low
);

    logic vblank_q;   // vblank one cycle ago
    logic vb_rise;
    logic pause_req;

    assign vb_rise   = vblank && !vblank_q;
    assign pause_req = game_pause || st.status.mister.pause; // same bit on mist

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vblank_q  <= 1'b0;
            dip_pause <= 1'b1;        // running
        end else begin
            vblank_q <= vblank;
            if (vb_rise) begin
                dip_pause <= ~pause_req; // whole frames only
            end
        end
    end

    // any change must come from the sample at a vblank rising edge
    a_pause_at_vblank : assert property (
        @(posedge clk) disable iff (!arst_n)
            !$stable(dip_pause) |-> $past(vb_rise)
    );

endmodule

`default_nettype wire

//--- rtl/osd_pkg.sv
`default_nettype none

package osd_pkg;

    // mist video mode in status[4:3]
    typedef enum logic [1:0] {
        pass_thru     = 2'd0,
        linear        = 2'd1,
        analogue      = 2'd2,
        analogue_scan = 2'd3
    } video_mode_t;

    // bit 0 set for a vertical game
    typedef logic [6:0] core_mod_t;

    typedef struct packed {
        logic [17:0] spare_hi;   // 31:14, core specific
        logic        flip;       // 13
        logic        credits;    // 12
        logic        wide;       // 11
        logic        test;       // 10
        logic        fm_off;     // 9
        logic        psg_off;    // 8
        logic [1:0]  fx_level;   // 7:6
        logic [2:0]  scanlines;  // 5:3 scandoubler fx level
        logic        rot_off;    // 2
        logic        pause;      // 1
        logic        spare_lo;   // 0 is the osd reset bit
    } status_mister_t;

    // same layout, scaler bits read as a video mode
    typedef struct packed {
        logic [17:0] spare_hi;
        logic        flip;
        logic        credits;
        logic        wide;
        logic        test;
        logic        fm_off;
        logic        psg_off;
        logic [1:0]  fx_level;
        logic        spare5;     // unused on mist
        video_mode_t video_mode; // 4:3
        logic        rot_ctl;    // 2 handed to the core
        logic        pause;
        logic        spare_lo;
    } status_mist_t;

    typedef union packed {
        status_mister_t mister;
        status_mist_t   mist;
    } status_t;

endpackage

`default_nettype wire

//--- rtl/osd_status_if.sv
`timescale 1ns/1ps
`default_nettype none

// committed settings from the loader to the decode blocks
interface osd_status_if;

    osd_pkg::status_t   status;   // whole word, never partial
    osd_pkg::core_mod_t core_mod;
    logic               upd;      // one cycle after a commit
    logic               busy;     // command partly received

    modport loader (
        output status,
        output core_mod,
        output upd,
        output busy
    );

    modport consumer (
        input status,
        input core_mod,
        input upd,
        input busy
    );

endinterface

`default_nettype wire

//--- rtl/osd_status_loader.sv
`timescale 1ns/1ps
`default_nettype none
`include "osd_defs.svh"

// parses the osd byte port into status and core mode
module osd_status_loader (
    input  wire logic       clk,
    input  wire logic       arst_n,
    input  wire logic       cmd_strobe,
    input  wire logic       cmd_start,
    input  wire logic [7:0] cmd_byte,
    osd_status_if.loader    st
);

    // parser states
    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_STAT = 2'd1; // collecting status bytes
    localparam logic [1:0] S_MOD  = 2'd2; // waiting for the core mode byte
    localparam logic [1:0] S_SKIP = 2'd3; // unknown code, drop data

    logic [1:0]         state;
    logic [1:0]         cnt;       // status bytes already taken
    logic [23:0]        stage;     // first three status bytes
    osd_pkg::status_t   status_q;
    osd_pkg::core_mod_t core_mod_q;
    logic               upd_q;

    logic data_stb;
    assign data_stb = cmd_strobe && !cmd_start;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= S_IDLE;
            cnt        <= 2'd0;
            status_q   <= `OSD_STATUS_RESET;
            core_mod_q <= '0;
            upd_q      <= 1'b0;
        end else begin
            upd_q <= 1'b0; // pulse only
            if (cmd_strobe && cmd_start) begin
                cnt <= 2'd0; // any code drops a partial command
                case (cmd_byte)
                    `OSD_CMD_STATUS:   state <= S_STAT;
                    `OSD_CMD_CORE_MOD: state <= S_MOD;
                    default:           state <= S_SKIP;
                endcase
            end else if (data_stb) begin
                case (state)
                    S_STAT: begin
                        if (cnt == 2'd3) begin
                            // fourth byte is the msb, commit the whole word
                            status_q <= {cmd_byte, stage};
                            upd_q    <= 1'b1;
                            state    <= S_IDLE;
                            cnt      <= 2'd0;
                        end else begin
                            cnt <= cnt + 2'd1;
                        end
                    end
                    S_MOD: begin
                        core_mod_q <= cmd_byte[6:0];
                        upd_q      <= 1'b1;
                        state      <= S_IDLE;
                    end
                    default: ; // idle or skip, byte ignored
                endcase
            end
        end
    end

    // staging shift register, lsb byte ends up in stage[7:0]
    always_ff @(posedge clk) begin
        if (data_stb && state == S_STAT) begin
            stage <= {cmd_byte, stage[23:8]};
        end
    end

    assign st.status   = status_q;
    assign st.core_mod = core_mod_q;
    assign st.upd      = upd_q;
    assign st.busy     = (state == S_STAT) || (state == S_MOD);

    // at most one byte per cycle, so two commits cannot be back to back
    a_upd_single : assert property (
        @(posedge clk) disable iff (!arst_n) st.upd |=> !st.upd
    );

endmodule

`default_nettype wire

//--- sim/osd_config_tb.sv
`timescale 1ns/1ps
`default_nettype none

// self-checking bench for the osd settings block, mister vertical build
module osd_config_tb;

    localparam int N_ROWS     = 13;
    localparam int N_RAND     = 20;
    localparam int VB_CYCLES  = 7;   // one vblank pulse incl. settle
    // reset + every setting (7 bytes of 2 cycles, plus settle) + vblanks + margin
    localparam int MAX_CYCLES = 16 + (N_ROWS + N_RAND + 6) * 16 + 3 * VB_CYCLES + 200;

    logic        clk, arst_n, cmd_strobe, cmd_start, game_pause, vblank;
    logic [7:0]  cmd_byte;
    logic [11:0] hdmi_arx, hdmi_ary;
    logic [1:0]  rotate, dip_fxlevel;
    logic [2:0]  scanlines;
    logic        rot_control, en_mixing, bw_en, blend_en, enable_fm, enable_psg;
    logic        osd_pause, dip_test, dip_flip, dip_pause;

    logic [73:0] tbl [N_ROWS];   // core mode, status, expected outputs
    int          errors, checks, tests, cycles;
    logic [31:0] lfsr_state;
    logic        pause_seen;     // dip_pause just after a vblank rise

    osd_config_top dut_i (
        .clk(clk), .arst_n(arst_n),
        .cmd_strobe(cmd_strobe), .cmd_start(cmd_start), .cmd_byte(cmd_byte),
        .game_pause(game_pause), .vblank(vblank),
        .hdmi_arx(hdmi_arx), .hdmi_ary(hdmi_ary), .rotate(rotate),
        .rot_control(rot_control), .en_mixing(en_mixing), .scanlines(scanlines),
        .bw_en(bw_en), .blend_en(blend_en), .enable_fm(enable_fm),
        .enable_psg(enable_psg), .osd_pause(osd_pause), .dip_test(dip_test),
        .dip_flip(dip_flip), .dip_fxlevel(dip_fxlevel), .dip_pause(dip_pause)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, the test sequence did not finish", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    // expected layout: arx, ary, scanlines, rotate, fm, psg, fxlevel, test, osd_pause
    task automatic fill_table();
        //         core    status         arx    ary    scan  rot    fm/psg fx     test/op
        tbl[0]  = {7'h00, 32'h0000_0000, 12'd4,  12'd3, 3'd0, 2'b10, 2'b11, 2'b10, 2'b10};
        tbl[1]  = {7'h00, 32'h0000_0800, 12'd16, 12'd9, 3'd0, 2'b10, 2'b11, 2'b10, 2'b10};
        tbl[2]  = {7'h00, 32'h0000_0028, 12'd4,  12'd3, 3'd5, 2'b10, 2'b11, 2'b10, 2'b10};
        tbl[3]  = {7'h00, 32'h0000_00C0, 12'd4,  12'd3, 3'd0, 2'b10, 2'b11, 2'b01, 2'b10};
        tbl[4]  = {7'h00, 32'h0000_0300, 12'd4,  12'd3, 3'd0, 2'b10, 2'b00, 2'b10, 2'b10};
        tbl[5]  = {7'h00, 32'h0000_1400, 12'd4,  12'd3, 3'd0, 2'b10, 2'b11, 2'b10, 2'b01};
        tbl[6]  = {7'h00, 32'h0000_2040, 12'd4,  12'd3, 3'd0, 2'b00, 2'b11, 2'b11, 2'b10};
        tbl[7]  = {7'h01, 32'h0000_0000, 12'd3,  12'd4, 3'd0, 2'b11, 2'b11, 2'b10, 2'b10};
        tbl[8]  = {7'h01, 32'h0000_0004, 12'd4,  12'd3, 3'd0, 2'b10, 2'b11, 2'b10, 2'b10};
        tbl[9]  = {7'h01, 32'h0000_0800, 12'd16, 12'd9, 3'd0, 2'b11, 2'b11, 2'b10, 2'b10};
        tbl[10] = {7'h01, 32'h0000_2018, 12'd3,  12'd4, 3'd3, 2'b01, 2'b11, 2'b10, 2'b10};
        tbl[11] = {7'h7E, 32'hABCD_0080, 12'd4,  12'd3, 3'd0, 2'b10, 2'b11, 2'b00, 2'b10};
        tbl[12] = {7'h01, 32'hFFFF_FFFF, 12'd16, 12'd9, 3'd7, 2'b00, 2'b00, 2'b01, 2'b01};
    endtask

    // decode rules for the mister target with rotation enabled
    function automatic logic [34:0] expect_decode(input logic [6:0] cm, input logic [31:0] s);
        logic        tate;
        logic [11:0] ax;
        logic [11:0] ay;
        tate = cm[0] & ~s[2];                  // vertical game, rotation not refused
        ax   = s[11] ? 12'd16 : (tate ? 12'd3 : 12'd4);
        ay   = s[11] ? 12'd9  : (tate ? 12'd4 : 12'd3);
        return {ax, ay, s[5:3], ~s[13], tate, ~s[9], ~s[8], s[7:6] ^ 2'b10, ~s[10], s[12]};
    endfunction

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_outputs(input logic [34:0] exp);
        check_val("hdmi_arx", hdmi_arx, exp[34:23]);
        check_val("hdmi_ary", hdmi_ary, exp[22:11]);
        check_val("scanlines", scanlines, exp[10:8]);
        check_val("rotate", rotate, exp[7:6]);
        check_val("enable_fm", enable_fm, exp[5]);
        check_val("enable_psg", enable_psg, exp[4]);
        check_val("dip_fxlevel", dip_fxlevel, exp[3:2]);
        check_val("dip_test", dip_test, exp[1]);
        check_val("osd_pause", osd_pause, exp[0]);
    endtask

    // filter and flip bits, mist-only controls stay low on mister
    task automatic check_misc(input logic [31:0] s);
        check_val("en_mixing", en_mixing, !s[3]);
        check_val("dip_flip", dip_flip, !s[13]);
        check_val("rot_control", rot_control, 1'b0);
        check_val("bw_en", bw_en, 1'b0);
        check_val("blend_en", blend_en, 1'b0);
    endtask

    task automatic report_test(input string name, input int err_start);
        tests++;
        $display("%-16s %s", name, (errors == err_start) ? "ok" : "FAILED");
    endtask

    // one byte per two cycles, strobe seen at the rising edge in between
    task automatic send_byte(input logic start, input logic [7:0] b);
        @(negedge clk);
        cmd_strobe = 1'b1;
        cmd_start  = start;
        cmd_byte   = b;
        @(negedge clk);
        cmd_strobe = 1'b0;
        cmd_start  = 1'b0;
    endtask

    task automatic send_status(input logic [31:0] s);
        send_byte(1'b1, 8'h1E);
        for (int i = 0; i < 4; i++) begin
            send_byte(1'b0, s[8*i +: 8]);   // lsb first
        end
    endtask

    // core mode, then status, checked 2 cycles after the last strobe
    task automatic apply_setting(input logic [6:0] cm, input logic [31:0] s);
        send_byte(1'b1, 8'h01);
        send_byte(1'b0, {1'b0, cm});
        send_status(s);
        @(negedge clk);   // decoder registers loaded at the edge just passed
    endtask

    task automatic vblank_pulse();
        @(negedge clk);
        vblank = 1'b1;
        @(negedge clk);
        pause_seen = dip_pause;   // rise sampled at the edge just passed
        repeat (3) @(negedge clk);
        vblank = 1'b0;
        repeat (2) @(negedge clk);
    endtask

    initial begin
        int          err_start;
        logic [31:0] word;
        logic [6:0]  cm;
        arst_n     = 1'b0;
        cmd_strobe = 1'b0;
        cmd_start  = 1'b0;
        cmd_byte   = 8'h00;
        game_pause = 1'b0;
        vblank     = 1'b0;
        lfsr_state = 32'h147f;
        fill_table();
        repeat (16) @(negedge clk);
        arst_n = 1'b1;
        repeat (2) @(negedge clk);

        err_start = errors;   // reset values are the zero-status decode
        check_outputs(expect_decode(7'h00, 32'h0));
        check_misc(32'h0);
        check_val("dip_pause", dip_pause, 1'b1);
        report_test("reset", err_start);

        for (int i = 0; i < N_ROWS; i++) begin
            err_start = errors;
            apply_setting(tbl[i][73:67], tbl[i][66:35]);
            check_outputs(tbl[i][34:0]);
            check_misc(tbl[i][66:35]);
            report_test($sformatf("row %0d", i), err_start);
        end

        err_start = errors;
        send_byte(1'b1, 8'h1E);   // status cut short after two bytes
        send_byte(1'b0, 8'h00);
        send_byte(1'b0, 8'h00);
        send_byte(1'b1, 8'h55);   // unknown code, data dropped
        repeat (4) send_byte(1'b0, 8'h00);
        repeat (4) @(negedge clk);
        check_outputs(tbl[N_ROWS-1][34:0]);
        check_misc(tbl[N_ROWS-1][66:35]);
        apply_setting(tbl[2][73:67], tbl[2][66:35]);
        check_outputs(tbl[2][34:0]);
        check_misc(tbl[2][66:35]);
        report_test("abort/unknown", err_start);

        err_start = errors;
        game_pause = 1'b1;        // mid-frame request
        repeat (5) @(negedge clk);
        check_val("dip_pause", dip_pause, 1'b1);
        vblank_pulse();
        check_val("dip_pause", pause_seen, 1'b0);
        send_status(32'h0000_0002);   // osd pause takes over
        game_pause = 1'b0;
        repeat (3) @(negedge clk);
        vblank_pulse();
        check_val("dip_pause", pause_seen, 1'b0);
        send_status(32'h0);
        repeat (3) @(negedge clk);
        check_val("dip_pause", dip_pause, 1'b0);   // held until next frame
        vblank_pulse();
        check_val("dip_pause", pause_seen, 1'b1);
        report_test("pause", err_start);

        for (int n = 0; n < N_RAND; n++) begin
            err_start = errors;
            for (int b = 0; b < 32; b++) begin
                word[b]    = lfsr_state[0];
                lfsr_state = lfsr_step(lfsr_state);
            end
            cm         = {6'd0, lfsr_state[0]};   // one more bit for the vertical flag
            lfsr_state = lfsr_step(lfsr_state);
            apply_setting(cm, word);
            check_outputs(expect_decode(cm, word));
            check_misc(word);
            report_test($sformatf("random %0d", n), err_start);
        end

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
